//--- logic/simd_data_pkg.sv
// Data types of the SIMD ALU datapath: operand word layout, element
// width encoding and per-byte flag vectors.
// Compile before alu_op_pkg and every module of the design.

package simd_data_pkg;

  // Datapath geometry
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // Element width, encoded as in vsew
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // One operand word read at each element width
  typedef union packed {
    logic [0:0][DATA_WIDTH-1:0]   w64;
    logic [1:0][DATA_WIDTH/2-1:0] w32;
    logic [3:0][DATA_WIDTH/4-1:0] w16;
    logic [7:0][DATA_WIDTH/8-1:0] w8;
  } simd_word_u;

  // One flag per byte
  // Wider lanes repeat their flag over all of their bytes
  typedef logic [STRB_WIDTH-1:0] byte_flags_t;

endpackage

//--- logic/alu_op_pkg.sv
// Operation encoding and the request and response words of the SIMD ALU.
// Compile after simd_data_pkg.

package alu_op_pkg;

  typedef enum logic [4:0] {
    // Bitwise logic
    VAND, VOR, VXOR,
    // Wrapping add and subtract
    VADD, VSUB, VRSUB,
    // Saturating add and subtract
    VSADDU, VSADD, VSSUBU, VSSUB,
    // Min and max
    VMINU, VMIN, VMAXU, VMAX,
    // Compares producing a mask bit per lane
    VMSEQ, VMSNE,
    VMSLTU, VMSLT,
    VMSLEU, VMSLE,
    VMSGTU, VMSGT,
    // Shifts
    VSLL, VSRL, VSRA
  } alu_op_e;

  // One request, 135 bits
  typedef struct packed {
    simd_data_pkg::simd_word_u operand_a;
    simd_data_pkg::simd_word_u operand_b;
    alu_op_e                   op;
    simd_data_pkg::vew_e       vew;
  } alu_req_t;

  // One response, 72 bits
  typedef struct packed {
    simd_data_pkg::simd_word_u  result;
    simd_data_pkg::byte_flags_t vxsat;
  } alu_resp_t;

endpackage

//--- logic/alu_compare.sv
// Lane comparator of the SIMD ALU. Flags b < a and a == b for every lane
// at the element width of the request, each at the first byte of its lane.

`timescale 1ns/1ns

module alu_compare (
  input  alu_op_pkg::alu_req_t       req_i,
  output simd_data_pkg::byte_flags_t less_o,
  output simd_data_pkg::byte_flags_t equal_o
);

  simd_data_pkg::simd_word_u opa;
  simd_data_pkg::simd_word_u opb;
  logic                      is_signed;

  assign opa = req_i.operand_a;
  assign opb = req_i.operand_b;

  // Signed flavours of min, max and the ordered compares
  assign is_signed = req_i.op inside {alu_op_pkg::VMIN, alu_op_pkg::VMAX, alu_op_pkg::VMSLT,
                                      alu_op_pkg::VMSLE, alu_op_pkg::VMSGT};

  // Flipping the sign bit turns a signed order into an unsigned one
  always_comb begin
    less_o  = '0;
    equal_o = '0;
    unique case (req_i.vew)
      simd_data_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          less_o[i]  = {opb.w8[i][7] ^ is_signed, opb.w8[i][6:0]} <
                       {opa.w8[i][7] ^ is_signed, opa.w8[i][6:0]};
          equal_o[i] = opa.w8[i] == opb.w8[i];
        end
      end
      simd_data_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          less_o[2*i]  = {opb.w16[i][15] ^ is_signed, opb.w16[i][14:0]} <
                         {opa.w16[i][15] ^ is_signed, opa.w16[i][14:0]};
          equal_o[2*i] = opa.w16[i] == opb.w16[i];
        end
      end
      simd_data_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          less_o[4*i]  = {opb.w32[i][31] ^ is_signed, opb.w32[i][30:0]} <
                         {opa.w32[i][31] ^ is_signed, opa.w32[i][30:0]};
          equal_o[4*i] = opa.w32[i] == opb.w32[i];
        end
      end
      simd_data_pkg::EW64: begin
        less_o[0]  = {opb.w64[0][63] ^ is_signed, opb.w64[0][62:0]} <
                     {opa.w64[0][63] ^ is_signed, opa.w64[0][62:0]};
        equal_o[0] = opa.w64[0] == opb.w64[0];
      end
    endcase
  end

endmodule

//--- logic/alu_adder.sv
// Lane adder of the SIMD ALU. Computes add, sub (b - a), reverse sub and
// the saturating add and sub for every lane, with per-byte saturation flags.
// Purely combinational; the result select picks its output by operation.

`timescale 1ns/1ns

module alu_adder (
  input  alu_op_pkg::alu_req_t       req_i,
  output simd_data_pkg::simd_word_u  sum_o,
  output simd_data_pkg::byte_flags_t vxsat_o
);

  simd_data_pkg::simd_word_u opa;
  simd_data_pkg::simd_word_u opb;
  logic                      is_signed;
  logic                      is_sat;
  logic [64:0]               lane;

  assign opa = req_i.operand_a;
  assign opb = req_i.operand_b;

  assign is_signed = req_i.op inside {alu_op_pkg::VSADD, alu_op_pkg::VSSUB};
  assign is_sat    = req_i.op inside {alu_op_pkg::VSADDU, alu_op_pkg::VSADD,
                                      alu_op_pkg::VSSUBU, alu_op_pkg::VSSUB};

  //////////////////////////////////////////////////////////////////////
  // Lane arithmetic

  // Sign or zero extension of a w-bit lane to 66 bits
  function automatic logic [65:0] widen(logic [63:0] x, int unsigned w, logic sgn);
    return ({66{sgn & x[w-1]}} << w) | 66'(x);
  endfunction

  // Result in the low w bits, saturation flag in bit 64
  function automatic logic [64:0] lane_op(logic [63:0] a, logic [63:0] b, int unsigned w);
    logic signed [65:0] ea;
    logic signed [65:0] eb;
    logic signed [65:0] r;
    logic signed [65:0] hi;
    logic signed [65:0] lo;
    logic               sat;
    ea = widen(a, w, is_signed);
    eb = widen(b, w, is_signed);
    unique case (req_i.op)
      alu_op_pkg::VADD, alu_op_pkg::VSADDU, alu_op_pkg::VSADD: r = ea + eb;
      alu_op_pkg::VRSUB: r = ea - eb;
      default:           r = eb - ea;
    endcase
    // No overflow in 66 bits, so the range check is exact
    hi  = is_signed ? (66'sd1 << (w - 1)) - 1 : (66'sd1 << w) - 1;
    lo  = is_signed ? -(66'sd1 << (w - 1)) : 66'sd0;
    sat = is_sat && (r > hi || r < lo);
    if (sat) begin
      r = (r > hi) ? hi : lo;
    end
    return {sat, r[63:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Lane split by element width

  always_comb begin
    sum_o   = '0;
    vxsat_o = '0;
    lane    = '0;
    unique case (req_i.vew)
      simd_data_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          lane        = lane_op(opa.w8[i], opb.w8[i], 8);
          sum_o.w8[i] = lane[7:0];
          vxsat_o[i]  = lane[64];
        end
      end
      simd_data_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          lane               = lane_op(opa.w16[i], opb.w16[i], 16);
          sum_o.w16[i]       = lane[15:0];
          vxsat_o[2*i +: 2]  = {2{lane[64]}};
        end
      end
      simd_data_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          lane               = lane_op(opa.w32[i], opb.w32[i], 32);
          sum_o.w32[i]       = lane[31:0];
          vxsat_o[4*i +: 4]  = {4{lane[64]}};
        end
      end
      simd_data_pkg::EW64: begin
        lane         = lane_op(opa.w64[0], opb.w64[0], 64);
        sum_o.w64[0] = lane[63:0];
        vxsat_o      = {8{lane[64]}};
      end
    endcase
  end

endmodule

//--- logic/alu_shifter.sv
// Lane shifter of the SIMD ALU. Shifts each lane of operand b by the low
// log2(lane width) bits of the matching lane of operand a.

`timescale 1ns/1ns

module alu_shifter (
  input  simd_data_pkg::simd_word_u operand_a_i,
  input  simd_data_pkg::simd_word_u operand_b_i,
  input  alu_op_pkg::alu_op_e       op_i,
  input  simd_data_pkg::vew_e       vew_i,
  output simd_data_pkg::simd_word_u shifted_o
);

  // One lane of w bits, result in the low w bits
  function automatic logic [63:0] shift_lane(logic [63:0] a, logic [63:0] b, int unsigned w);
    logic [5:0]  amount;
    logic [63:0] fill;
    amount = a[5:0] & 6'(w - 1);
    // Sign copies above the lane for the arithmetic shift
    fill   = (op_i == alu_op_pkg::VSRA && b[w-1]) ? ({64{1'b1}} << w) : '0;
    unique case (op_i)
      alu_op_pkg::VSLL: return b << amount;
      alu_op_pkg::VSRA: return $signed(b | fill) >>> amount;
      default:          return b >> amount;
    endcase
  endfunction

  always_comb begin
    shifted_o = '0;
    unique case (vew_i)
      simd_data_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          shifted_o.w8[i] = 8'(shift_lane(operand_a_i.w8[i], operand_b_i.w8[i], 8));
        end
      end
      simd_data_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          shifted_o.w16[i] = 16'(shift_lane(operand_a_i.w16[i], operand_b_i.w16[i], 16));
        end
      end
      simd_data_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          shifted_o.w32[i] = 32'(shift_lane(operand_a_i.w32[i], operand_b_i.w32[i], 32));
        end
      end
      simd_data_pkg::EW64: begin
        shifted_o.w64[0] = shift_lane(operand_a_i.w64[0], operand_b_i.w64[0], 64);
      end
    endcase
  end

endmodule

//--- logic/alu_result_select.sv
// Result stage of the SIMD ALU datapath. Does the bitwise ops, forms
// min/max and compare masks from the lane flags, and picks the unit
// result that matches the operation.

`timescale 1ns/1ns

module alu_result_select (
  input  alu_op_pkg::alu_req_t       req_i,
  input  simd_data_pkg::byte_flags_t less_i,
  input  simd_data_pkg::byte_flags_t equal_i,
  input  simd_data_pkg::simd_word_u  sum_i,
  input  simd_data_pkg::byte_flags_t vxsat_i,
  input  simd_data_pkg::simd_word_u  shifted_i,
  output alu_op_pkg::alu_resp_t      resp_o
);

  simd_data_pkg::simd_word_u  opa;
  simd_data_pkg::simd_word_u  opb;
  simd_data_pkg::simd_word_u  res;
  simd_data_pkg::byte_flags_t outcome;
  simd_data_pkg::byte_flags_t lead;
  logic [2:0]                 lane_mask;

  assign opa       = req_i.operand_a;
  assign opb       = req_i.operand_b;
  // Byte index bits inside one lane
  assign lane_mask = 3'((1 << req_i.vew) - 1);

  //////////////////////////////////////////////////////////////////////
  // Lane outcome, valid at the first byte of each lane

  always_comb begin
    for (int k = 0; k < simd_data_pkg::STRB_WIDTH; k++) begin
      lead[k] = (k & int'(lane_mask)) == 0;
    end
    unique case (req_i.op)
      alu_op_pkg::VMSEQ:                    outcome = equal_i;
      alu_op_pkg::VMSNE:                    outcome = ~equal_i;
      alu_op_pkg::VMSLEU, alu_op_pkg::VMSLE: outcome = less_i | equal_i;
      alu_op_pkg::VMSGTU, alu_op_pkg::VMSGT: outcome = ~(less_i | equal_i);
      // Max keeps b unless b < a
      alu_op_pkg::VMAXU, alu_op_pkg::VMAX:   outcome = ~less_i;
      default:                              outcome = less_i;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Final choice

  always_comb begin
    res = '0;
    unique case (req_i.op)
      alu_op_pkg::VAND: res = opa & opb;
      alu_op_pkg::VOR:  res = opa | opb;
      alu_op_pkg::VXOR: res = opa ^ opb;
      alu_op_pkg::VADD, alu_op_pkg::VSUB, alu_op_pkg::VRSUB, alu_op_pkg::VSADDU,
      alu_op_pkg::VSADD, alu_op_pkg::VSSUBU, alu_op_pkg::VSSUB: res = sum_i;
      alu_op_pkg::VSLL, alu_op_pkg::VSRL, alu_op_pkg::VSRA: res = shifted_i;
      alu_op_pkg::VMINU, alu_op_pkg::VMIN, alu_op_pkg::VMAXU, alu_op_pkg::VMAX: begin
        for (int k = 0; k < simd_data_pkg::STRB_WIDTH; k++) begin
          res.w8[k] = outcome[k & ~int'(lane_mask)] ? opb.w8[k] : opa.w8[k];
        end
      end
      alu_op_pkg::VMSEQ, alu_op_pkg::VMSNE, alu_op_pkg::VMSLTU, alu_op_pkg::VMSLT,
      alu_op_pkg::VMSLEU, alu_op_pkg::VMSLE, alu_op_pkg::VMSGTU, alu_op_pkg::VMSGT: begin
        // Mask bit in bit 0 of the lane, rest zero
        for (int k = 0; k < simd_data_pkg::STRB_WIDTH; k++) begin
          res.w8[k] = {7'b0, outcome[k] & lead[k]};
        end
      end
      default: res = '0;
    endcase
  end

  assign resp_o = '{result: res, vxsat: vxsat_i};

endmodule

//--- logic/alu_output_reg.sv
// One-entry output register of the SIMD ALU. Captures a response when
// valid_i and ready_o meet and holds it until the consumer takes it.

`timescale 1ns/1ns

module alu_output_reg (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  alu_op_pkg::alu_resp_t resp_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output alu_op_pkg::alu_resp_t resp_o
);

  logic                  full_q;
  alu_op_pkg::alu_resp_t resp_q;

  // Free when empty or when the held response leaves on this edge
  assign ready_o = ~full_q | ready_i;
  assign valid_o = full_q;
  assign resp_o  = resp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      resp_q <= resp_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions

  a_stall_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(resp_o))
    else $error("alu_output_reg: response changed while stalled");

  a_reset_empty : assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else $error("alu_output_reg: valid_o high after reset");

endmodule

//--- logic/simd_alu.sv
// Registered 64-bit SIMD vector ALU. Takes one request per valid/ready
// transfer and returns the result word and per-byte vxsat one cycle later
// through a valid/ready output stage.

`timescale 1ns/1ns

module simd_alu (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  alu_op_pkg::alu_req_t  req_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output alu_op_pkg::alu_resp_t resp_o
);

  simd_data_pkg::byte_flags_t less;
  simd_data_pkg::byte_flags_t equal;
  simd_data_pkg::byte_flags_t vxsat;
  simd_data_pkg::simd_word_u  sum;
  simd_data_pkg::simd_word_u  shifted;
  alu_op_pkg::alu_resp_t      resp_next;

  //////////////////////////////////////////////////////////////////////
  // Combinational lane units

  alu_compare u_compare (
    .req_i   (req_i),
    .less_o  (less),
    .equal_o (equal)
  );

  alu_adder u_adder (
    .req_i   (req_i),
    .sum_o   (sum),
    .vxsat_o (vxsat)
  );

  alu_shifter u_shifter (
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .op_i        (req_i.op),
    .vew_i       (req_i.vew),
    .shifted_o   (shifted)
  );

  alu_result_select u_result_select (
    .req_i     (req_i),
    .less_i    (less),
    .equal_i   (equal),
    .sum_i     (sum),
    .vxsat_i   (vxsat),
    .shifted_i (shifted),
    .resp_o    (resp_next)
  );

  // Output stage
  alu_output_reg u_output_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .resp_i  (resp_next),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .resp_o  (resp_o)
  );

endmodule

//--- verification/simd_alu_model.svh
// Reference model of the SIMD ALU for the testbench scoreboard.
// Include inside the testbench module and call once per accepted request.

`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

function automatic alu_op_pkg::alu_resp_t simd_alu_model(alu_op_pkg::alu_req_t req);
  alu_op_pkg::alu_resp_t resp;
  int unsigned           w;
  int unsigned           nbytes;
  logic [63:0]           mask;
  logic [63:0]           msb;
  logic [63:0]           a;
  logic [63:0]           b;
  logic [63:0]           r;
  logic [5:0]            sh;
  logic                  sgn;
  logic                  lt;
  logic                  sat;
  w      = 8 << req.vew;
  nbytes = w / 8;
  mask   = (w == 64) ? '1 : (64'd1 << w) - 1;
  msb    = 64'd1 << (w - 1);
  sgn    = req.op inside {alu_op_pkg::VMIN, alu_op_pkg::VMAX, alu_op_pkg::VMSLT,
                          alu_op_pkg::VMSLE, alu_op_pkg::VMSGT};
  resp   = '0;
  for (int l = 0; l < 64 / w; l++) begin
    a   = (req.operand_a >> (l * w)) & mask;
    b   = (req.operand_b >> (l * w)) & mask;
    sh  = 6'(a & (w - 1));
    sat = 1'b0;
    // Signed order is unsigned order with the sign bit flipped
    lt  = sgn ? ((b ^ msb) < (a ^ msb)) : (b < a);
    case (req.op)
      alu_op_pkg::VAND:  r = a & b;
      alu_op_pkg::VOR:   r = a | b;
      alu_op_pkg::VXOR:  r = a ^ b;
      alu_op_pkg::VADD:  r = a + b;
      alu_op_pkg::VSUB:  r = b - a;
      alu_op_pkg::VRSUB: r = a - b;
      alu_op_pkg::VSADDU: begin
        r   = (a + b) & mask;
        sat = r < a;
        if (sat) r = mask;
      end
      alu_op_pkg::VSSUBU: begin
        sat = a > b;
        r   = sat ? '0 : b - a;
      end
      alu_op_pkg::VSADD: begin
        r   = (a + b) & mask;
        sat = ((a ^ b) & msb) == 0 && ((r ^ a) & msb) != 0;
        if (sat) r = (a & msb) != 0 ? msb : msb - 1;
      end
      alu_op_pkg::VSSUB: begin
        r   = (b - a) & mask;
        sat = ((a ^ b) & msb) != 0 && ((r ^ b) & msb) != 0;
        if (sat) r = (b & msb) != 0 ? msb : msb - 1;
      end
      alu_op_pkg::VSLL: r = b << sh;
      alu_op_pkg::VSRL: r = b >> sh;
      alu_op_pkg::VSRA: r = $signed(b | ((b & msb) != 0 ? ~mask : '0)) >>> sh;
      alu_op_pkg::VMIN, alu_op_pkg::VMINU: r = lt ? b : a;
      alu_op_pkg::VMAX, alu_op_pkg::VMAXU: r = lt ? a : b;
      alu_op_pkg::VMSEQ: r = 64'(a == b);
      alu_op_pkg::VMSNE: r = 64'(a != b);
      alu_op_pkg::VMSLT, alu_op_pkg::VMSLTU: r = 64'(lt);
      alu_op_pkg::VMSLE, alu_op_pkg::VMSLEU: r = 64'(lt || a == b);
      alu_op_pkg::VMSGT, alu_op_pkg::VMSGTU: r = 64'(!lt && a != b);
      default: r = '0;
    endcase
    resp.result = resp.result | ((r & mask) << (l * w));
    if (sat) resp.vxsat = resp.vxsat | 8'(((1 << nbytes) - 1) << (l * nbytes));
  end
  return resp;
endfunction

`endif

//--- verification/tb_simd_alu.sv
// Testbench for the registered SIMD ALU. Drives random requests from a fixed
// seed, predicts every response with the reference model and checks the
// output stream in order, including stalls under random back-pressure.

`timescale 1ns/1ns

module tb_simd_alu;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int N_BASIC      = 200;
  localparam int N_SAT        = 200;
  localparam int N_CMP        = 200;
  localparam int N_BP         = 300;
  localparam int N_TOTAL      = N_BASIC + N_SAT + N_CMP + N_BP;

  logic                  clk_i;
  logic                  reset_i;
  logic                  valid_i;
  logic                  ready_o;
  logic                  valid_o;
  logic                  ready_i;
  alu_op_pkg::alu_req_t  req_i;
  alu_op_pkg::alu_resp_t resp_o;

  alu_op_pkg::alu_resp_t expected_q[$];
  alu_op_pkg::alu_resp_t exp_resp;
  alu_op_pkg::alu_resp_t held_resp;
  logic                  stalled = 1'b0;
  logic                  bp_mode = 1'b0;
  integer                seed = 74148;
  int                    issued = 0;
  int                    received = 0;
  int                    errors = 0;
  int                    errors_before = 0;

  alu_op_pkg::alu_op_e basic_ops [9] = '{alu_op_pkg::VAND, alu_op_pkg::VOR, alu_op_pkg::VXOR,
                                         alu_op_pkg::VADD, alu_op_pkg::VSUB, alu_op_pkg::VRSUB,
                                         alu_op_pkg::VSLL, alu_op_pkg::VSRL, alu_op_pkg::VSRA};
  alu_op_pkg::alu_op_e sat_ops [4] = '{alu_op_pkg::VSADDU, alu_op_pkg::VSADD,
                                       alu_op_pkg::VSSUBU, alu_op_pkg::VSSUB};

  `include "simd_alu_model.svh"

  simd_alu uut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .req_i   (req_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .resp_o  (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #((RESET_CYCLES + 40 * N_TOTAL) * CLK_PERIOD);
    $display("Watchdog expired at %0t ns with %0d responses outstanding", $time,
             expected_q.size());
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic simd_data_pkg::vew_e rand_vew();
    return simd_data_pkg::vew_e'(2'($random(seed)));
  endfunction

  // Lanes near zero, all ones and the signed limits
  function automatic logic [63:0] extreme_word(simd_data_pkg::vew_e vew);
    int unsigned w;
    logic [63:0] mask;
    logic [63:0] msb;
    logic [63:0] v;
    logic [63:0] word;
    w    = 8 << vew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 1;
    msb  = 64'd1 << (w - 1);
    word = '0;
    for (int l = 0; l < 64 / w; l++) begin
      case ({$random(seed)} % 6)
        0:       v = '0;
        1:       v = mask;
        2:       v = msb;
        3:       v = msb - 1;
        4:       v = 64'd1;
        default: v = rand_word();
      endcase
      word = word | ((v & mask) << (l * w));
    end
    return word;
  endfunction

  // Copies whole lanes of a into b so that some lanes compare equal
  function automatic logic [63:0] share_lanes(logic [63:0] a, logic [63:0] b,
                                              simd_data_pkg::vew_e vew);
    logic [7:0]  pick;
    int unsigned nbytes;
    logic [63:0] r;
    pick   = 8'($random(seed));
    nbytes = 1 << vew;
    r      = b;
    for (int k = 0; k < 8; k++) begin
      if (pick[k & ~(nbytes - 1)]) r[8*k +: 8] = a[8*k +: 8];
    end
    return r;
  endfunction

  // Samples ready_o at the edge, then drives 2 ns later
  task automatic next_cycle(output logic ready_seen);
    @(posedge clk_i);
    ready_seen = ready_o;
    #2;
    ready_i = bp_mode ? 1'($random(seed)) : 1'b1;
  endtask

  task automatic issue(input logic [63:0] a, input logic [63:0] b,
                       input alu_op_pkg::alu_op_e op, input simd_data_pkg::vew_e vew);
    alu_op_pkg::alu_req_t req;
    logic                 seen;
    req.operand_a = a;
    req.operand_b = b;
    req.op        = op;
    req.vew       = vew;
    req_i         = req;
    valid_i       = 1'b1;
    seen          = 1'b0;
    while (!seen) next_cycle(seen);
    expected_q.push_back(simd_alu_model(req));
    issued++;
    valid_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    logic seen;
    while (expected_q.size() != 0) next_cycle(seen);
    $display("%s: finished with %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboard

  always @(posedge clk_i) begin
    if (stalled) begin
      assert (valid_o && resp_o == held_resp) else begin
        $display("Error: resp_o while stalled expected %h got %h (valid_o %h)",
                 held_resp, resp_o, valid_o);
        errors++;
      end
    end
    if (!reset_i && valid_o && ready_i) begin
      assert (expected_q.size() != 0) else begin
        $display("A response arrived with no request outstanding");
        errors++;
      end
      if (expected_q.size() != 0) begin
        exp_resp = expected_q.pop_front();
        received++;
        assert (resp_o.result == exp_resp.result) else begin
          $display("Error: resp_o.result expected %h got %h", exp_resp.result, resp_o.result);
          errors++;
        end
        assert (resp_o.vxsat == exp_resp.vxsat) else begin
          $display("Error: resp_o.vxsat expected %h got %h", exp_resp.vxsat, resp_o.vxsat);
          errors++;
        end
      end
    end
    stalled   = !reset_i && valid_o && !ready_i;
    held_resp = resp_o;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    simd_data_pkg::vew_e vew;
    logic [63:0]         a;
    logic                seen;
    reset_i = 1'b1;
    valid_i = 1'b0;
    // Consumer held off so that ready_o reflects the empty register
    ready_i = 1'b0;
    req_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    assert (valid_o == 1'b0 && ready_o == 1'b1) else begin
      $display("Error: after reset valid_o %h ready_o %h", valid_o, ready_o);
      errors++;
    end
    end_test("Test 1 reset");

    for (int n = 0; n < N_BASIC; n++) begin
      issue(rand_word(), rand_word(), basic_ops[{$random(seed)} % 9], rand_vew());
    end
    end_test("Test 2 bitwise, wrapping add/sub and shifts");

    for (int n = 0; n < N_SAT; n++) begin
      vew = rand_vew();
      issue(extreme_word(vew), extreme_word(vew), sat_ops[{$random(seed)} % 4], vew);
    end
    end_test("Test 3 saturating add/sub");

    for (int n = 0; n < N_CMP; n++) begin
      vew = rand_vew();
      a   = ({$random(seed)} % 2) ? extreme_word(vew) : rand_word();
      issue(a, share_lanes(a, rand_word(), vew),
            alu_op_pkg::alu_op_e'(5'(alu_op_pkg::VMINU + {$random(seed)} % 12)), vew);
    end
    end_test("Test 4 min/max and compares");

    bp_mode = 1'b1;
    for (int n = 0; n < N_BP; n++) begin
      issue(rand_word(), rand_word(), alu_op_pkg::alu_op_e'(5'({$random(seed)} % 25)),
            rand_vew());
      if ({$random(seed)} % 4 == 0) next_cycle(seen);
    end
    end_test("Test 5 back-pressure");
    bp_mode = 1'b0;

    assert (issued == received) else begin
      $display("Lost or duplicated responses: %0d issued, %0d received", issued, received);
      errors++;
    end
    $display("Issued %0d, received %0d, errors %0d", issued, received, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+verification
logic/simd_data_pkg.sv
logic/alu_op_pkg.sv
logic/alu_compare.sv
logic/alu_adder.sv
logic/alu_shifter.sv
logic/alu_result_select.sv
logic/alu_output_reg.sv
logic/simd_alu.sv
verification/tb_simd_alu.sv

//--- run.sh
#!/bin/sh
# Builds the SIMD ALU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_simd_alu -f list.f -o sim_tb_simd_alu

./obj_dir/sim_tb_simd_alu | tee sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi
